// File: src/lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// ----------------------------------------------------------
// HD44780 command codes
// ----------------------------------------------------------
`define LCD_CMD_SETUP     8'h38   // 8-bit bus, 2 lines, 5x7 font
`define LCD_CMD_DISP_OFF  8'h08   // Display, cursor and blink off
`define LCD_CMD_DISP_ON   8'h0C   // Display on, no cursor
`define LCD_CMD_CLEAR     8'h01   // Clear screen, cursor home
`define LCD_CMD_HOME      8'h02   // Return home only
`define LCD_CMD_ENTRY     8'h06   // Increment, no display shift

// ----------------------------------------------------------
// Wait lengths in microseconds, scaled by clk_mhz in RTL
// ----------------------------------------------------------
`define LCD_T_POWERUP_US  14'd15000   // Worst case power-up
`define LCD_T_4100_US     14'd4100    // After first function set
`define LCD_T_100_US      14'd100     // After later function sets
`define LCD_T_1640_US     14'd1640    // Clear and home
`define LCD_T_42_US       14'd42      // Everything else

`define LCD_E_HIGH_CYCLES 6           // Min E pulse width in clocks

// Wishbone word addresses
`define LCD_ADR_DATA      2'd0
`define LCD_ADR_INSTR     2'd1
`define LCD_ADR_CLEAR     2'd2
`define LCD_ADR_STATUS    2'd3

`define LCD_STAT_BUSY_BIT 0           // Status word bit positions
`define LCD_STAT_INIT_BIT 1

`endif

// File: src/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// Wait class that follows a strobe
	typedef enum logic [1:0] {
		w42   = 2'd0,   // Normal instruction or character
		w100  = 2'd1,   // Later function sets during init
		w1640 = 2'd2,   // Clear or home
		w4100 = 2'd3    // First function set
	} lcd_wait_e;

	typedef struct packed {
		logic       rs;           // High for character, low for instruction
		logic [7:0] code;         // Byte placed on DB
		lcd_wait_e  wait_class;   // Busy time after the strobe
	} lcd_cmd_t;

	typedef struct packed {
		logic       rs;
		logic       rw;           // Tied low, the LCD is never read
		logic       e;
		logic [7:0] db;
	} lcd_pins_t;

	// ----------------------------------------------------------
	// Wishbone classic, 2-bit word address, 8-bit data
	// ----------------------------------------------------------
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [1:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: src/lcd_init_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_init_seq #(
	parameter int clk_mhz = 24
) (
	input  logic              CLK,
	input  logic              RST,
	output logic              req,
	output lcd_pkg::lcd_cmd_t cmd,
	input  logic              done
);

	localparam int PWR_CYC = `LCD_T_POWERUP_US * clk_mhz;   // Power-up wait in clocks
	localparam int PWR_W   = $clog2(PWR_CYC + 1);
	localparam logic [3:0] LAST_IDX = 4'd8;                  // Nine table entries

	typedef enum logic [1:0] {s_pwr, s_run, s_fin} seq_state_e;

	seq_state_e       state;
	logic [PWR_W-1:0] pwr_cnt;
	logic [3:0]       idx;

	always_ff @(posedge CLK) begin
		if (RST) begin
			state   <= s_pwr;
			pwr_cnt <= PWR_W'(PWR_CYC - 1);
			idx     <= 4'd0;
		end else begin
			case (state)
				s_pwr: begin
					if (pwr_cnt == '0) state <= s_run;   // 15 ms elapsed
					else pwr_cnt <= pwr_cnt - 1'b1;
				end
				s_run: begin
					if (done) begin
						if (idx == LAST_IDX) state <= s_fin;   // Sequence complete
						else idx <= idx + 1'b1;              // Next entry
					end
				end
				default: state <= s_fin;   // Stays here until reset
			endcase
		end
	end

	assign req = (state == s_run);

	// ----------------------------------------------------------
	// Power-up command table, all instructions
	// ----------------------------------------------------------
	always_comb begin
		cmd.rs = 1'b0;
		case (idx)
			4'd0:          cmd = '{1'b0, `LCD_CMD_SETUP, lcd_pkg::w4100};
			4'd1, 4'd2, 4'd3: cmd = '{1'b0, `LCD_CMD_SETUP, lcd_pkg::w100};
			4'd4:          cmd = '{1'b0, `LCD_CMD_DISP_OFF, lcd_pkg::w42};
			4'd5:          cmd = '{1'b0, `LCD_CMD_CLEAR, lcd_pkg::w1640};
			4'd6:          cmd = '{1'b0, `LCD_CMD_ENTRY, lcd_pkg::w42};
			4'd7:          cmd = '{1'b0, `LCD_CMD_DISP_ON, lcd_pkg::w42};
			default:       cmd = '{1'b0, `LCD_CMD_CLEAR, lcd_pkg::w1640};   // Final clear
		endcase
	end

	// Engine samples cmd at any point while req is up
	a_cmd_stable: assert property (@(posedge CLK) disable iff (RST)
		req && !done |=> $stable(cmd));

endmodule

`default_nettype wire

// File: src/lcd_wb_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_wb_port (
	input  logic              CLK,
	input  logic              RST,
	input  lcd_pkg::wb_req_t  wb_req,
	output lcd_pkg::wb_rsp_t  wb_rsp,
	output logic              req,
	output lcd_pkg::lcd_cmd_t cmd,
	input  logic              done,
	input  logic              busy,
	input  logic              init_done
);

	logic              ack_q;
	logic              req_q;
	logic [7:0]        rdat_q;
	logic [7:0]        stat_w;
	logic              start;
	logic              is_wr_cmd;
	lcd_pkg::lcd_cmd_t dec_cmd;
	lcd_pkg::lcd_cmd_t cmd_q;

	// New access only once the previous one is fully closed
	assign start     = wb_req.cyc && wb_req.stb && !ack_q && !req_q;
	assign is_wr_cmd = wb_req.we && (wb_req.adr != `LCD_ADR_STATUS);

	always_comb begin
		stat_w                     = '0;
		stat_w[`LCD_STAT_BUSY_BIT] = busy;
		stat_w[`LCD_STAT_INIT_BIT] = init_done;
	end

	// ----------------------------------------------------------
	// Address decode into an LCD command
	// ----------------------------------------------------------
	always_comb begin
		dec_cmd.rs         = 1'b0;
		dec_cmd.code       = wb_req.dat;
		dec_cmd.wait_class = lcd_pkg::w42;
		case (wb_req.adr)
			`LCD_ADR_DATA: dec_cmd.rs = 1'b1;   // Character write
			`LCD_ADR_INSTR: begin
				if (wb_req.dat == `LCD_CMD_CLEAR || wb_req.dat == `LCD_CMD_HOME)
					dec_cmd.wait_class = lcd_pkg::w1640;   // Slow instructions
			end
			`LCD_ADR_CLEAR: begin
				dec_cmd.code       = `LCD_CMD_CLEAR;
				dec_cmd.wait_class = lcd_pkg::w1640;
			end
			default: dec_cmd.rs = 1'b0;   // Status, no command
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RST) begin
			ack_q <= 1'b0;
			req_q <= 1'b0;
		end else begin
			ack_q <= 1'b0;   // Single-cycle ack
			if (start && is_wr_cmd) req_q <= 1'b1;   // Hold until engine done
			else if (start) ack_q <= 1'b1;          // Status read or write
			if (req_q && done) begin
				req_q <= 1'b0;
				ack_q <= 1'b1;   // Write complete on the LCD
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (start && is_wr_cmd) cmd_q <= dec_cmd;
		if (start) rdat_q <= stat_w;
	end

	assign req    = req_q;
	assign cmd    = cmd_q;
	assign wb_rsp = '{ack: ack_q, dat: rdat_q};

	// Master must keep the strobe up until ack
	a_ack_in_cycle: assert property (@(posedge CLK) disable iff (RST)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb);
	a_one_ack: assert property (@(posedge CLK) disable iff (RST)
		wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

// File: src/lcd_bus_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_bus_engine #(
	parameter int clk_mhz = 24
) (
	input  logic               CLK,
	input  logic               RST,
	input  logic               init_req,
	input  lcd_pkg::lcd_cmd_t  init_cmd,
	output logic               init_done_pulse,
	input  logic               host_req,
	input  lcd_pkg::lcd_cmd_t  host_cmd,
	output logic               host_done,
	output logic               busy,
	output logic               init_done,
	output lcd_pkg::lcd_pins_t pins
);

	localparam int CNT_W = $clog2(`LCD_T_4100_US * clk_mhz + 1);   // Longest wait

	typedef enum logic [1:0] {st_idle, st_setup, st_strobe, st_wait} eng_state_e;

	eng_state_e         state;
	logic [CNT_W-1:0]   cnt;            // Shared by strobe and wait phases
	logic               owner_host;     // Source of the command in flight
	logic               init_seen;      // Sequencer has issued at least once
	logic               e_q;
	logic               rs_q;
	logic [7:0]         db_q;
	lcd_pkg::lcd_wait_e wait_q;
	logic               host_go;
	logic               accept;
	logic               done;
	lcd_pkg::lcd_cmd_t  sel_cmd;

	function automatic logic [CNT_W-1:0] wait_len(input lcd_pkg::lcd_wait_e wc);
		case (wc)
			lcd_pkg::w42:   return CNT_W'(`LCD_T_42_US * clk_mhz - 1);
			lcd_pkg::w100:  return CNT_W'(`LCD_T_100_US * clk_mhz - 1);
			lcd_pkg::w1640: return CNT_W'(`LCD_T_1640_US * clk_mhz - 1);
			default:        return CNT_W'(`LCD_T_4100_US * clk_mhz - 1);
		endcase
	endfunction

	// ----------------------------------------------------------
	// Arbitration, sequencer first, host only after init
	// ----------------------------------------------------------
	assign host_go = host_req && init_done && !init_req;
	assign accept  = (state == st_idle) && (init_req || host_go);
	assign sel_cmd = init_req ? init_cmd : host_cmd;

	always_ff @(posedge CLK) begin
		if (RST) begin
			state      <= st_idle;
			cnt        <= '0;
			e_q        <= 1'b0;
			owner_host <= 1'b0;
			init_seen  <= 1'b0;
			init_done  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						owner_host <= !init_req;
						init_seen  <= init_seen | init_req;
						state      <= st_setup;
					end else if (init_seen) begin
						init_done <= 1'b1;   // Sequencer dropped req for good
					end
				end
				st_setup: begin
					e_q   <= 1'b1;   // RS/DB settled for one cycle
					cnt   <= CNT_W'(`LCD_E_HIGH_CYCLES - 1);
					state <= st_strobe;
				end
				st_strobe: begin
					if (cnt == '0) begin
						e_q   <= 1'b0;   // Falling edge latches DB
						cnt   <= wait_len(wait_q);
						state <= st_wait;
					end else cnt <= cnt - 1'b1;
				end
				default: begin
					if (cnt == '0) state <= st_idle;
					else cnt <= cnt - 1'b1;
				end
			endcase
		end
	end

	// Bus payload, held between commands
	always_ff @(posedge CLK) begin
		if (accept) begin
			rs_q   <= sel_cmd.rs;
			db_q   <= sel_cmd.code;
			wait_q <= sel_cmd.wait_class;
		end
	end

	assign done            = (state == st_wait) && (cnt == '0);
	assign init_done_pulse = done && !owner_host;
	assign host_done       = done && owner_host;
	assign busy            = (state != st_idle);
	assign pins            = '{rs: rs_q, rw: 1'b0, e: e_q, db: db_q};

	a_e_low_in_wait: assert property (@(posedge CLK) disable iff (RST)
		(state == st_wait) |-> !pins.e);
	a_rw_low: assert property (@(posedge CLK) disable iff (RST) !pins.rw);
	a_done_busy: assert property (@(posedge CLK) disable iff (RST)
		(init_done_pulse || host_done) |-> busy);

endmodule

`default_nettype wire

// File: src/lcd_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top #(
	parameter int clk_mhz = 24   // Scales every microsecond delay
) (
	input  logic               CLK,
	input  logic               RST,
	input  lcd_pkg::wb_req_t   wb_req,
	output lcd_pkg::wb_rsp_t   wb_rsp,
	output lcd_pkg::lcd_pins_t lcd
);

	// ----------------------------------------------------------
	// Command sources to bus engine
	// ----------------------------------------------------------
	logic              init_req;
	lcd_pkg::lcd_cmd_t init_cmd;
	logic              init_done_pulse;
	logic              host_req;
	lcd_pkg::lcd_cmd_t host_cmd;
	logic              host_done;
	logic              busy;
	logic              init_done;

	lcd_init_seq #(.clk_mhz(clk_mhz)) u_init_seq (
		.CLK  (CLK),
		.RST  (RST),
		.req  (init_req),
		.cmd  (init_cmd),
		.done (init_done_pulse)
	);

	lcd_wb_port u_wb_port (
		.CLK       (CLK),
		.RST       (RST),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.req       (host_req),
		.cmd       (host_cmd),
		.done      (host_done),
		.busy      (busy),
		.init_done (init_done)
	);

	lcd_bus_engine #(.clk_mhz(clk_mhz)) u_bus_engine (
		.CLK             (CLK),
		.RST             (RST),
		.init_req        (init_req),
		.init_cmd        (init_cmd),
		.init_done_pulse (init_done_pulse),
		.host_req        (host_req),
		.host_cmd        (host_cmd),
		.host_done       (host_done),
		.busy            (busy),
		.init_done       (init_done),
		.pins            (lcd)
	);

endmodule

`default_nettype wire

// File: dv/lcd_bus_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_bus_monitor (
	input  logic               CLK,
	input  logic               RST,
	input  lcd_pkg::lcd_pins_t lcd,
	output logic               err
);

	logic [7:0]  db_q[$];     // Strobed bytes in bus order
	logic        rs_q[$];
	int unsigned rise_q[$];   // Cycle of each E rise
	int unsigned fall_q[$];   // Cycle of each E fall
	int unsigned n_log;
	int unsigned cyc_cnt;     // Falling edges seen so far
	int unsigned high_cnt;    // Cycles E has been high
	int unsigned t_rise;
	logic        e_prev;
	logic        rs_hold;
	logic [7:0]  db_hold;

	initial begin
		err      = 1'b0;
		n_log    = 0;
		cyc_cnt  = 0;
		high_cnt = 0;
		t_rise   = 0;
		e_prev   = 1'b0;
	end

	// Log is emptied on every reset
	always @(posedge CLK) begin
		if (RST) begin
			db_q.delete();
			rs_q.delete();
			rise_q.delete();
			fall_q.delete();
			n_log = 0;
		end
	end

	// ----------------------------------------------------------
	// Strobe tracking, pins are stable on the falling edge
	// ----------------------------------------------------------
	always @(negedge CLK) begin
		if (lcd.e && !e_prev) begin
			rs_hold  = lcd.rs;   // Byte captured at E rise
			db_hold  = lcd.db;
			high_cnt = 1;
			t_rise   = cyc_cnt;
		end else if (lcd.e) begin
			high_cnt++;
			assert (lcd.db == db_hold) else begin
				$display("[FAIL] t=%0t lcd.db expected 0x%0h actual 0x%0h", $time, db_hold, lcd.db);
				err = 1'b1;
			end
			assert (lcd.rs == rs_hold) else begin
				$display("[FAIL] t=%0t lcd.rs expected %0b actual %0b", $time, rs_hold, lcd.rs);
				err = 1'b1;
			end
		end else if (e_prev) begin
			assert (high_cnt >= `LCD_E_HIGH_CYCLES) else begin
				$display("[FAIL] t=%0t lcd.e high cycles expected %0d actual %0d", $time,
					`LCD_E_HIGH_CYCLES, high_cnt);
				err = 1'b1;
			end
			db_q.push_back(db_hold);   // E fell, byte taken by the LCD
			rs_q.push_back(rs_hold);
			rise_q.push_back(t_rise);
			fall_q.push_back(cyc_cnt);
			n_log++;
		end
		e_prev = lcd.e;
		cyc_cnt++;
	end

endmodule

`default_nettype wire

// File: dv/lcd_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_tb;

	localparam int CLK_MHZ   = 1;
	localparam int SEED      = 87020;
	localparam int LOG_LIMIT = 40000;   // Cycles, power-up plus whole init table
	localparam int ACK_LIMIT = 40000;   // A write may stall through a full init

	logic               CLK;
	logic               RST;
	lcd_pkg::wb_req_t   wb_req;
	lcd_pkg::wb_rsp_t   wb_rsp;
	lcd_pkg::lcd_pins_t lcd;
	logic               mon_err;
	int unsigned        rst_cyc;            // Monitor cycle count after RST fell
	logic [7:0]         init_code [0:8];    // Expected power-up bytes
	int unsigned        init_wait [0:8];    // Expected busy wait after each, us

	lcd_ctrl_top #(.clk_mhz(CLK_MHZ)) dut (
		.CLK    (CLK),
		.RST    (RST),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.lcd    (lcd)
	);

	lcd_bus_monitor mon (.CLK(CLK), .RST(RST), .lcd(lcd), .err(mon_err));

	always #2 CLK = ~CLK;   // 4 ns period

	// ----------------------------------------------------------
	// Error handling
	// ----------------------------------------------------------
	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input int unsigned exp,
		input int unsigned act);
		$display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
		stop_run();
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		stop_run();
	endtask

	always @(posedge mon_err) stop_run();   // Strobe rule broken on the pins

	// ----------------------------------------------------------
	// Reset, Wishbone and wait helpers
	// ----------------------------------------------------------
	task automatic do_reset();
		@(negedge CLK);
		RST    = 1'b1;
		wb_req = '0;
		repeat (4) @(negedge CLK);
		RST = 1'b0;
		@(posedge CLK);
		rst_cyc = mon.cyc_cnt;   // First rising edge out of reset
	endtask

	task automatic wait_ack();
		int unsigned n;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
			if (n > ACK_LIMIT) report_timeout("Wishbone ack");
		end while (!wb_rsp.ack);
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
		@(negedge CLK);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wait_ack();
		@(negedge CLK);   // Ack taken on the rising edge in between
		wb_req = '0;
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [7:0] dat);
		@(negedge CLK);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b0;
		wb_req.adr = adr;
		wb_req.dat = 8'h00;
		wait_ack();
		dat = wb_rsp.dat;
		@(negedge CLK);
		wb_req = '0;
	endtask

	task automatic wait_for_log(input int unsigned count);
		int unsigned n;
		n = 0;
		while (mon.n_log < count) begin
			@(posedge CLK);
			n++;
			if (n > LOG_LIMIT) report_timeout("strobed bytes on the LCD bus");
		end
	endtask

	task automatic wait_until_cycle(input int unsigned target);
		int unsigned n;
		n = 0;
		while (mon.cyc_cnt < target) begin
			@(posedge CLK);
			n++;
			if (n > LOG_LIMIT) report_timeout("the end of the last init wait");
		end
	endtask

	task automatic check_entry(input int unsigned idx, input logic rs, input logic [7:0] code);
		assert (mon.n_log > idx) else report_mismatch("logged byte count", idx + 1, mon.n_log);
		assert (mon.db_q[idx] == code) else report_mismatch("lcd.db", code, mon.db_q[idx]);
		assert (mon.rs_q[idx] == rs) else report_mismatch("lcd.rs", rs, mon.rs_q[idx]);
	endtask

	// Gap from the previous E fall to this E rise
	task automatic check_gap(input int unsigned idx, input int unsigned min_cyc);
		int unsigned gap;
		gap = mon.rise_q[idx] - mon.fall_q[idx - 1];
		assert (gap >= min_cyc) else report_mismatch("lcd.e fall to rise (min)", min_cyc, gap);
	endtask

	// ----------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------
	task automatic test_init_sequence();
		@(negedge CLK);
		assert (lcd.e == 1'b0) else report_mismatch("lcd.e", 0, lcd.e);
		assert (lcd.rw == 1'b0) else report_mismatch("lcd.rw", 0, lcd.rw);
		wait_for_log(9);
		assert (mon.rise_q[0] - rst_cyc >= 15000 * CLK_MHZ)
			else report_mismatch("power-up cycles (min)", 15000 * CLK_MHZ, mon.rise_q[0] - rst_cyc);
		for (int i = 0; i < 9; i++) begin
			check_entry(i, 1'b0, init_code[i]);
			if (i > 0) check_gap(i, init_wait[i - 1] * CLK_MHZ);
		end
	endtask

	task automatic test_status();
		logic [7:0] st;
		wb_read(`LCD_ADR_STATUS, st);   // Still inside the final clear wait
		assert (st[`LCD_STAT_INIT_BIT] == 1'b0)
			else report_mismatch("status init_done", 0, st[`LCD_STAT_INIT_BIT]);
		assert (st[`LCD_STAT_BUSY_BIT] == 1'b1)
			else report_mismatch("status busy", 1, st[`LCD_STAT_BUSY_BIT]);
		wait_until_cycle(mon.fall_q[8] + 1640 * CLK_MHZ + 10);
		wb_read(`LCD_ADR_STATUS, st);
		assert (st[`LCD_STAT_INIT_BIT] == 1'b1)
			else report_mismatch("status init_done", 1, st[`LCD_STAT_INIT_BIT]);
		assert (st[`LCD_STAT_BUSY_BIT] == 1'b0)
			else report_mismatch("status busy", 0, st[`LCD_STAT_BUSY_BIT]);
	endtask

	task automatic test_data_writes();
		logic [7:0]  ch;
		int unsigned idx;
		for (int i = 0; i < 10; i++) begin
			ch  = $urandom % 256;
			idx = mon.n_log;
			wb_write(`LCD_ADR_DATA, ch);
			check_entry(idx, 1'b1, ch);
		end
	endtask

	task automatic test_instr_and_clear();
		logic [7:0]  code;
		int unsigned idx;
		for (int i = 0; i < 4; i++) begin
			code = $urandom % 256;
			while (code == `LCD_CMD_CLEAR || code == `LCD_CMD_HOME)
				code = $urandom % 256;   // Slow codes belong to the clear case
			idx = mon.n_log;
			wb_write(`LCD_ADR_INSTR, code);
			check_entry(idx, 1'b0, code);
			check_gap(idx, 42 * CLK_MHZ);
		end
		idx = mon.n_log;
		wb_write(`LCD_ADR_CLEAR, $urandom % 256);   // Data bits ignored here
		check_entry(idx, 1'b0, 8'h01);
		check_gap(idx, 42 * CLK_MHZ);
		wb_write(`LCD_ADR_DATA, 8'h41);
		check_entry(idx + 1, 1'b1, 8'h41);
		check_gap(idx + 1, 1640 * CLK_MHZ);
	endtask

	task automatic test_stall_during_init();
		logic [7:0] ch;
		ch = $urandom % 256;
		do_reset();
		wb_write(`LCD_ADR_DATA, ch);   // Held off until init is over
		assert (mon.n_log == 10) else report_mismatch("logged byte count at ack", 10, mon.n_log);
		for (int i = 0; i < 9; i++)
			check_entry(i, 1'b0, init_code[i]);
		check_entry(9, 1'b1, ch);
	endtask

	initial begin
		CLK    = 1'b0;
		RST    = 1'b1;
		wb_req = '0;
		void'($urandom(SEED));
		init_code = '{`LCD_CMD_SETUP, `LCD_CMD_SETUP, `LCD_CMD_SETUP, `LCD_CMD_SETUP,
			`LCD_CMD_DISP_OFF, `LCD_CMD_CLEAR, `LCD_CMD_ENTRY, `LCD_CMD_DISP_ON, `LCD_CMD_CLEAR};
		init_wait = '{4100, 100, 100, 100, 42, 1640, 42, 42, 1640};
		do_reset();
		test_init_sequence();
		test_status();
		test_data_writes();
		test_instr_and_clear();
		test_stall_during_init();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/lcd_pkg.sv
src/lcd_init_seq.sv
src/lcd_wb_port.sv
src/lcd_bus_engine.sv
src/lcd_ctrl_top.sv
dv/lcd_bus_monitor.sv
dv/lcd_tb.sv

// File: Bender.yml
package:
  name: lcd_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/lcd_pkg.sv
      - src/lcd_init_seq.sv
      - src/lcd_wb_port.sv
      - src/lcd_bus_engine.sv
      - src/lcd_ctrl_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/lcd_bus_monitor.sv
      - dv/lcd_tb.sv
